// File: files.f
src/cicPkg.sv
src/cicRegs.sv
src/gainShifter.sv
src/cicIntegrators.sv
src/cicCombDecimator.sv
src/cicDecimator.sv
verif/cicChecker.sv
verif/tbCicDecimator.sv

// File: src/cicCombDecimator.sv
`default_nettype none

module cicCombDecimator
    import cicPkg::*;
#(
    parameter int AccW = AccWidth,
    parameter int OutW = SampleWidth,
    parameter int DecW = DecWidth
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            sync,
    input  wire logic [DecW-1:0] cicDecimation,
    input  wire logic [AccW-1:0] accI2,
    input  wire logic [AccW-1:0] accQ2,
    output logic      [OutW-1:0] outI,
    output logic      [OutW-1:0] outQ,
    output logic                 syncOut
);

    localparam int Channels = 2;

    logic [DecW-1:0] decCount;

    logic [Channels-1:0][AccW-1:0] accIn;
    logic [Channels-1:0][AccW:0]   x;       // One guard bit over the accumulator
    logic [Channels-1:0][AccW:0]   x3;
    logic [Channels-1:0][AccW:0]   sum3;
    logic [Channels-1:0][AccW:0]   tap0;
    logic [Channels-1:0][AccW:0]   tap1;
    logic [Channels-1:0][AccW:0]   tap2;
    logic [Channels-1:0][AccW-1:0] tap3;

    // Strobe on every (decimation + 1)-th enabled sample
    always_ff @(posedge clk) begin
        if (reset) begin
            decCount <= DecW'(1);
            syncOut  <= 1'b0;
        end else if (sync) begin
            if (decCount == '0) begin
                decCount <= cicDecimation;                          // New value applies here
                syncOut  <= 1'b1;
            end else begin
                decCount <= decCount - 1'b1;
                syncOut  <= 1'b0;
            end
        end
    end

    assign accIn[0] = accI2;
    assign accIn[1] = accQ2;

    always_comb begin
        for (int ch = 0; ch < Channels; ch++) begin
            x[ch]    = {accIn[ch][AccW-1], accIn[ch]};
            x3[ch]   = x[ch] + {accIn[ch], 1'b0};
            sum3[ch] = tap2[ch] + x[ch];
        end
    end

    // Transposed (1 - z)^3 comb giving y = x - 3x[-1] + 3x[-2] - x[-3]
    always_ff @(posedge clk) begin
        if (reset) begin
            tap0 <= '0;
            tap1 <= '0;
            tap2 <= '0;
            tap3 <= '0;
        end else if (syncOut) begin
            for (int ch = 0; ch < Channels; ch++) begin
                tap0[ch] <= x[ch];
                tap1[ch] <= x3[ch] - tap0[ch];
                tap2[ch] <= tap1[ch] - x3[ch];
                tap3[ch] <= sum3[ch][AccW-1:0];
            end
        end
    end

    assign outI = tap3[0][AccW-1 -: OutW];
    assign outQ = tap3[1][AccW-1 -: OutW];

    // A reload of a nonzero decimation must hold the strobe off at the next sample
    strobeSpacing: assert property (@(posedge clk) disable iff (reset)
        (sync && syncOut && cicDecimation != '0 && $stable(cicDecimation)) |=> !syncOut)
        else $error("syncOut high on consecutive samples, decimation %0d", cicDecimation);

endmodule

`default_nettype wire

// File: src/cicDecimator.sv
`default_nettype none

module cicDecimator
    import cicPkg::*;
#(
    parameter int SampleW = SampleWidth,
    parameter int AccW    = AccWidth,
    parameter int DecW    = DecWidth,
    parameter int ShW     = ShiftWidth
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      sync,
    input  wire logic                      wr0,
    input  wire logic                      wr1,
    input  wire logic                      wr2,
    input  wire logic                      wr3,
    input  wire logic      [AddrWidth-1:0] addr,
    input  wire logic      [DataWidth-1:0] din,
    output logic           [DataWidth-1:0] dout,
    input  wire logic signed [SampleW-1:0] inI,
    input  wire logic signed [SampleW-1:0] inQ,
    output logic             [SampleW-1:0] outI,
    output logic             [SampleW-1:0] outQ,
    output logic                           syncOut
);

    logic [DecW-1:0] cicDecimation;
    logic [ShW-1:0]  cicShift;
    logic [AccW-1:0] shiftI;
    logic [AccW-1:0] shiftQ;
    logic [AccW-1:0] accI2;
    logic [AccW-1:0] accQ2;

    cicRegs #(.DecW(DecW), .ShW(ShW)) regs (
        .clk(clk), .reset(reset), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout), .cicDecimation(cicDecimation), .cicShift(cicShift)
    );

    gainShifter #(.InW(SampleW), .OutW(AccW), .ShW(ShW)) iShifter (
        .clk(clk), .reset(reset), .sync(sync), .shift(cicShift), .din(inI), .dout(shiftI)
    );

    gainShifter #(.InW(SampleW), .OutW(AccW), .ShW(ShW)) qShifter (
        .clk(clk), .reset(reset), .sync(sync), .shift(cicShift), .din(inQ), .dout(shiftQ)
    );

    cicIntegrators #(.AccW(AccW)) integrators (
        .clk(clk), .reset(reset), .sync(sync),
        .shiftI(shiftI), .shiftQ(shiftQ), .accI2(accI2), .accQ2(accQ2)
    );

    cicCombDecimator #(.AccW(AccW), .OutW(SampleW), .DecW(DecW)) combDecimator (
        .clk(clk), .reset(reset), .sync(sync), .cicDecimation(cicDecimation),
        .accI2(accI2), .accQ2(accQ2), .outI(outI), .outQ(outQ), .syncOut(syncOut)
    );

endmodule

`default_nettype wire

// File: src/cicIntegrators.sv
`default_nettype none

module cicIntegrators
    import cicPkg::*;
#(
    parameter int AccW = AccWidth
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            sync,
    input  wire logic [AccW-1:0] shiftI,
    input  wire logic [AccW-1:0] shiftQ,
    output logic      [AccW-1:0] accI2,
    output logic      [AccW-1:0] accQ2
);

    localparam int Stages   = 3;
    localparam int Channels = 2;

    logic [Channels-1:0][AccW-1:0]             chanIn;
    logic [Channels-1:0][Stages-1:0][AccW-1:0] acc;

    assign chanIn[0] = shiftI;
    assign chanIn[1] = shiftQ;

    // Each stage adds the value the stage before it held last cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (sync) begin
            for (int ch = 0; ch < Channels; ch++) begin
                acc[ch][0] <= acc[ch][0] + chanIn[ch];              // Wraps modulo 2^AccW
                for (int st = 1; st < Stages; st++) begin
                    acc[ch][st] <= acc[ch][st] + acc[ch][st-1];
                end
            end
        end
    end

    assign accI2 = acc[0][Stages-1];
    assign accQ2 = acc[1][Stages-1];

endmodule

`default_nettype wire

// File: src/cicPkg.sv
`default_nettype none

package cicPkg;

    // Register bus
    localparam int AddrWidth   = 12;
    localparam int DataWidth   = 32;
    localparam int ByteLanes   = DataWidth / 8;
    localparam int OffsetWidth = 4;

    // Data path
    localparam int SampleWidth = 18;
    localparam int AccWidth    = 48;
    localparam int DecWidth    = 10;
    localparam int ShiftWidth  = 5;

    // Largest shift that keeps a full-scale sample inside the accumulator
    localparam int MaxShift = AccWidth - SampleWidth;

    // Address space select above the OffsetWidth-bit register offset
    localparam logic [AddrWidth-1:0] CicBase = 12'h100;

    localparam int DecResetValue   = 7;
    localparam int ShiftResetValue = 0;

    typedef enum logic [OffsetWidth-1:0] {
        RegDecimation = 4'h0,   // Bits 9:0
        RegShift      = 4'h4    // Bits 4:0
    } regAddrT;

endpackage

`default_nettype wire

// File: src/cicRegs.sv
`default_nettype none

module cicRegs
    import cicPkg::*;
#(
    parameter int DecW = DecWidth,
    parameter int ShW  = ShiftWidth
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [AddrWidth-1:0] addr,
    input  wire logic [DataWidth-1:0] din,
    input  wire logic                 wr0,
    input  wire logic                 wr1,
    input  wire logic                 wr2,
    input  wire logic                 wr3,
    output logic      [DataWidth-1:0] dout,
    output logic      [DecW-1:0]      cicDecimation,
    output logic      [ShW-1:0]       cicShift
);

    logic                 cs;
    regAddrT              regOffset;
    logic [ByteLanes-1:0] wrStrobe;
    logic [DataWidth-1:0] decMerged;
    logic [DataWidth-1:0] shiftMerged;

    // Replace the strobed byte lanes of a register value with bus data
    function automatic logic [DataWidth-1:0] mergeLanes(
        input logic [DataWidth-1:0] current,
        input logic [DataWidth-1:0] data,
        input logic [ByteLanes-1:0] strobe
    );
        logic [DataWidth-1:0] merged;
        merged = current;
        for (int lane = 0; lane < ByteLanes; lane++) begin
            if (strobe[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign cs        = (addr[AddrWidth-1:OffsetWidth] == CicBase[AddrWidth-1:OffsetWidth]);
    assign regOffset = regAddrT'(addr[OffsetWidth-1:0]);
    assign wrStrobe  = {wr3, wr2, wr1, wr0};

    assign decMerged   = mergeLanes(DataWidth'(cicDecimation), din, wrStrobe);
    assign shiftMerged = mergeLanes(DataWidth'(cicShift), din, wrStrobe);

    always_ff @(posedge clk) begin
        if (reset) begin
            cicDecimation <= DecW'(DecResetValue);
            cicShift      <= ShW'(ShiftResetValue);
        end else if (cs && |wrStrobe) begin
            case (regOffset)
                RegDecimation: cicDecimation <= decMerged[DecW-1:0];
                RegShift:      cicShift      <= shiftMerged[ShW-1:0];
                default:       ;                                    // Unmapped offset
            endcase
        end
    end

    always_comb begin
        dout = '0;
        if (cs) begin
            case (regOffset)
                RegDecimation: dout = DataWidth'(cicDecimation);
                RegShift:      dout = DataWidth'(cicShift);
                default:       dout = '0;
            endcase
        end
    end

    shiftInRange: assert property (@(posedge clk) disable iff (reset)
        (cs && regOffset == RegShift && wrStrobe[0]) |=> (cicShift <= MaxShift))
        else $error("Gain shift %0d overflows the accumulator", cicShift);

endmodule

`default_nettype wire

// File: src/gainShifter.sv
`default_nettype none

module gainShifter
    import cicPkg::*;
#(
    parameter int InW  = SampleWidth,
    parameter int OutW = AccWidth,
    parameter int ShW  = ShiftWidth
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  sync,
    input  wire logic        [ShW-1:0] shift,
    input  wire logic signed [InW-1:0] din,
    output logic            [OutW-1:0] dout
);

    logic [OutW-1:0] extended;

    assign extended = {{(OutW-InW){din[InW-1]}}, din};     // Sign extension

    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else if (sync) begin
            dout <= extended << shift;
        end
    end

endmodule

`default_nettype wire

// File: verif/cicChecker.sv
`default_nettype none

module cicChecker
    import cicPkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   sync,
    input  wire logic [AddrWidth-1:0]   addr,
    input  wire logic [DataWidth-1:0]   din,
    input  wire logic                   wr0,
    input  wire logic                   wr1,
    input  wire logic                   wr2,
    input  wire logic                   wr3,
    input  wire logic [DataWidth-1:0]   dout,
    input  wire logic [SampleWidth-1:0] inI,
    input  wire logic [SampleWidth-1:0] inQ,
    input  wire logic [SampleWidth-1:0] outI,
    input  wire logic [SampleWidth-1:0] outQ,
    input  wire logic                   syncOut,
    output int                          errorCount,
    output int                          checkCount
);

    logic [DecWidth-1:0]    decReg;
    logic [ShiftWidth-1:0]  shiftReg;
    logic [AccWidth-1:0]    scaledI;
    logic [AccWidth-1:0]    scaledQ;
    logic [AccWidth-1:0]    integI [3];
    logic [AccWidth-1:0]    integQ [3];
    logic [AccWidth-1:0]    pastI [3];         // Comb inputs one, two and three strobes back
    logic [AccWidth-1:0]    pastQ [3];
    logic [DecWidth-1:0]    count;
    logic                   strobe;
    logic [SampleWidth-1:0] expOutI;
    logic [SampleWidth-1:0] expOutQ;
    logic                   modelValid;
    logic [3:0]             lanes;

    assign lanes = {wr3, wr2, wr1, wr0};

    function automatic logic inSpace(input logic [AddrWidth-1:0] a);
        return a[AddrWidth-1:OffsetWidth] == CicBase[AddrWidth-1:OffsetWidth];
    endfunction

    function automatic logic [DataWidth-1:0] laneWrite(input logic [DataWidth-1:0] old,
                                                       input logic [DataWidth-1:0] data,
                                                       input logic [3:0] strobes);
        logic [DataWidth-1:0] mask;
        mask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic [AccWidth-1:0] scaleSample(input logic [SampleWidth-1:0] s,
                                                        input logic [ShiftWidth-1:0] sh);
        logic signed [AccWidth-1:0] wide;
        wide = $signed(s);
        return wide << sh;
    endfunction

    // Top bits of the 48-bit third difference
    function automatic logic [SampleWidth-1:0] combSlice(input logic [AccWidth-1:0] x0,
                                                         input logic [AccWidth-1:0] x1,
                                                         input logic [AccWidth-1:0] x2,
                                                         input logic [AccWidth-1:0] x3);
        logic [AccWidth-1:0] y;
        y = x0 - 3 * x1 + 3 * x2 - x3;
        return y[AccWidth-1 -: SampleWidth];
    endfunction

    function automatic logic [DataWidth-1:0] readValue(input logic [AddrWidth-1:0] a);
        if (!inSpace(a)) begin
            return '0;
        end
        if (a[OffsetWidth-1:0] == RegDecimation) begin
            return DataWidth'(decReg);
        end
        if (a[OffsetWidth-1:0] == RegShift) begin
            return DataWidth'(shiftReg);
        end
        return '0;
    endfunction

    task automatic checkValue(input string name, input logic [DataWidth-1:0] actual,
                              input logic [DataWidth-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s at %0t: got 0x%h, expected 0x%h", name, $time, actual, expected);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        modelValid = 1'b0;
    end

    always @(posedge clk) begin
        if (modelValid) begin                  // DUT values from before this edge
            checkValue("syncOut", DataWidth'(syncOut), DataWidth'(strobe));
            checkValue("outI", DataWidth'(outI), DataWidth'(expOutI));
            checkValue("outQ", DataWidth'(outQ), DataWidth'(expOutQ));
            checkValue("dout", dout, readValue(addr));
        end
        if (reset) begin
            modelValid <= 1'b1;
            decReg     <= DecWidth'(7);
            shiftReg   <= '0;
            scaledI    <= '0;
            scaledQ    <= '0;
            count      <= DecWidth'(1);
            strobe     <= 1'b0;
            expOutI    <= '0;
            expOutQ    <= '0;
            for (int k = 0; k < 3; k++) begin
                integI[k] <= '0;
                integQ[k] <= '0;
                pastI[k]  <= '0;
                pastQ[k]  <= '0;
            end
        end else begin
            if (inSpace(addr) && |lanes) begin
                if (addr[OffsetWidth-1:0] == RegDecimation) begin
                    decReg <= DecWidth'(laneWrite(DataWidth'(decReg), din, lanes));
                end else if (addr[OffsetWidth-1:0] == RegShift) begin
                    shiftReg <= ShiftWidth'(laneWrite(DataWidth'(shiftReg), din, lanes));
                end
            end
            if (sync) begin
                scaledI   <= scaleSample(inI, shiftReg);
                scaledQ   <= scaleSample(inQ, shiftReg);
                integI[0] <= integI[0] + scaledI;
                integI[1] <= integI[1] + integI[0];
                integI[2] <= integI[2] + integI[1];
                integQ[0] <= integQ[0] + scaledQ;
                integQ[1] <= integQ[1] + integQ[0];
                integQ[2] <= integQ[2] + integQ[1];
                if (count == '0) begin
                    count  <= decReg;
                    strobe <= 1'b1;
                end else begin
                    count  <= count - 1'b1;
                    strobe <= 1'b0;
                end
            end
            if (strobe) begin                  // Comb runs on every cycle the strobe is high
                expOutI  <= combSlice(integI[2], pastI[0], pastI[1], pastI[2]);
                expOutQ  <= combSlice(integQ[2], pastQ[0], pastQ[1], pastQ[2]);
                pastI[0] <= integI[2];
                pastI[1] <= pastI[0];
                pastI[2] <= pastI[1];
                pastQ[0] <= integQ[2];
                pastQ[1] <= pastQ[0];
                pastQ[2] <= pastQ[1];
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tbCicDecimator.sv
`default_nettype none

module tbCicDecimator
    import cicPkg::*;
();

    localparam int NumRows     = 9;
    localparam int SyncEvery   = 0;
    localparam int KindConst   = 0;
    localparam int KindImpulse = 1;

    // Each row holds decimation, shift, sample count, sync mode (0 every cycle, 1 random),
    // input kind (0 constant, 1 impulse, 2 random), I and Q amplitudes, a mid-run
    // decimation (-1 for none) and the settled outputs of constant rows
    int tabDec     [NumRows] = '{7, 3, 15, 4, 5, 7, 9, 6, 0};
    int tabShift   [NumRows] = '{21, 24, 18, 10, 12, 16, 30, 20, 5};
    int tabSamples [NumRows] = '{200, 120, 300, 150, 100, 300, 300, 300, 150};
    int tabSync    [NumRows] = '{0, 0, 0, 0, 0, 1, 0, 0, 1};
    int tabKind    [NumRows] = '{0, 0, 0, 0, 1, 2, 2, 2, 2};
    int tabAmpI    [NumRows] = '{1000, -20000, -131072, 100000, 50000, 0, 0, 0, 0};
    int tabAmpQ    [NumRows] = '{-1500, 131071, 77, -100000, -70000, 0, 0, 0, 0};
    int tabNewDec  [NumRows] = '{-1, -1, -1, -1, -1, -1, -1, 2, -1};
    int tabExpI    [NumRows] = '{1000, -20000, -131072, 11, 0, 0, 0, 0, 0};
    int tabExpQ    [NumRows] = '{-1500, 131071, 77, -12, 0, 0, 0, 0, 0};

    logic                          clk;
    logic                          reset;
    logic                          sync;
    logic                          wr0;
    logic                          wr1;
    logic                          wr2;
    logic                          wr3;
    logic        [AddrWidth-1:0]   addr;
    logic        [DataWidth-1:0]   din;
    logic        [DataWidth-1:0]   dout;
    logic signed [SampleWidth-1:0] inI;
    logic signed [SampleWidth-1:0] inQ;
    logic        [SampleWidth-1:0] outI;
    logic        [SampleWidth-1:0] outQ;
    logic                          syncOut;
    int                            errorCount;
    int                            checkCount;
    int                            cycleCount;
    int                            cycleLimit;

    cicDecimator u_cicDecimator (
        .clk(clk), .reset(reset), .sync(sync),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .inI(inI), .inQ(inQ), .outI(outI), .outQ(outQ), .syncOut(syncOut)
    );

    cicChecker outChecker (
        .clk(clk), .reset(reset), .sync(sync), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .dout(dout),
        .inI(inI), .inQ(inQ), .outI(outI), .outQ(outQ), .syncOut(syncOut),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    function automatic int cycleBudget();
        int total;
        total = 200;
        for (int r = 0; r < NumRows; r++) begin
            total += 4 * tabSamples[r];
        end
        return total;
    endfunction

    function automatic logic [SampleWidth-1:0] stimulusSample(input int kind, input int amp,
                                                              input int index);
        if (kind == KindConst) begin
            return SampleWidth'(amp);
        end
        if (kind == KindImpulse) begin
            return (index == 0) ? SampleWidth'(amp) : '0;
        end
        return SampleWidth'($urandom);
    endfunction

    task automatic writeReg(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] data,
                            input logic [3:0] strobes);
        @(negedge clk);
        sync = 1'b0;
        addr = a;
        din  = data;
        {wr3, wr2, wr1, wr0} = strobes;
        @(negedge clk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic readReg(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] expected);
        @(negedge clk);
        sync = 1'b0;
        addr = a;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        @(negedge clk);
        outChecker.checkValue("dout", dout, expected);
    endtask

    task automatic registerTests();
        readReg(12'h100, 32'd7);                              // Reset defaults
        readReg(12'h104, 32'd0);
        writeReg(12'h100, 32'h0000_0155, 4'b1111);
        readReg(12'h100, 32'h0000_0155);
        writeReg(12'h100, 32'hFFFF_FFFF, 4'b0010);            // Only bits 9:8 live in byte 1
        readReg(12'h100, 32'h0000_0355);
        writeReg(12'h100, 32'h1234_56AB, 4'b0001);
        readReg(12'h100, 32'h0000_03AB);
        writeReg(12'h104, 32'h0000_0013, 4'b1111);
        readReg(12'h104, 32'h0000_0013);
        writeReg(12'h104, 32'hFFFF_FF0C, 4'b0001);
        readReg(12'h104, 32'h0000_000C);
        writeReg(12'h104, 32'hFFFF_FFFF, 4'b1110);
        readReg(12'h104, 32'h0000_000C);
        writeReg(12'h108, 32'hFFFF_FFFF, 4'b1111);            // Unmapped offset
        readReg(12'h108, 32'd0);
        readReg(12'h10C, 32'd0);
        writeReg(12'h204, 32'h0000_0001, 4'b1111);            // Outside CIC space
        readReg(12'h204, 32'd0);
        readReg(12'h104, 32'h0000_000C);
        readReg(12'h000, 32'd0);
        readReg(12'h1F0, 32'd0);
    endtask

    task automatic runRow(input int r);
        int                     sent;
        logic                   changed;
        logic                   syncNow;
        logic [SampleWidth-1:0] expI;
        logic [SampleWidth-1:0] expQ;
        sent    = 0;
        changed = 1'b0;
        expI    = tabExpI[r][SampleWidth-1:0];
        expQ    = tabExpQ[r][SampleWidth-1:0];
        writeReg(12'h100, DataWidth'(tabDec[r]), 4'b1111);
        writeReg(12'h104, DataWidth'(tabShift[r]), 4'b1111);
        while (sent < tabSamples[r]) begin
            if (tabNewDec[r] >= 0 && !changed && sent == tabSamples[r] / 2) begin
                writeReg(12'h100, DataWidth'(tabNewDec[r]), 4'b1111);
                changed = 1'b1;
            end
            @(negedge clk);
            syncNow = (tabSync[r] == SyncEvery) ? 1'b1 : 1'($urandom % 2);
            sync    = syncNow;
            inI     = stimulusSample(tabKind[r], tabAmpI[r], sent);
            inQ     = stimulusSample(tabKind[r], tabAmpQ[r], sent);
            if (syncNow) begin
                sent++;
            end
        end
        @(negedge clk);
        sync = 1'b0;
        if (tabKind[r] == KindConst) begin                    // DC gain reached
            outChecker.checkValue("outI", DataWidth'(outI), DataWidth'(expI));
            outChecker.checkValue("outQ", DataWidth'(outQ), DataWidth'(expQ));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycleLimit = cycleBudget();
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hae866f55));
        reset = 1'b1;
        sync  = 1'b0;
        wr0   = 1'b0;
        wr1   = 1'b0;
        wr2   = 1'b0;
        wr3   = 1'b0;
        addr  = '0;
        din   = '0;
        inI   = '0;
        inQ   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        registerTests();
        for (int r = 0; r < NumRows; r++) begin
            runRow(r);
        end
        repeat (5) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
